/* hw/vfp_commit_accumulator.sv */
// Collects the vector-register writes of one instruction into a wide commit, merges scalar write-backs
`timescale 1ns/1ps
`default_nettype none

module vfp_commit_accumulator #(
   parameter int VLEN = 256
) (
   input  wire                        i_clk,
   input  wire                        i_reset,

   input  wire [$clog2(VLEN+1)-1:0]   i_csr_vl,

   // Vector register write from the load queue
   input  wire                        i_vrf_wr,
   input  wire [VLEN-1:0]             i_vrf_wrdata,
   input  vfp_pkg::fflags_t           i_vrf_wrexc,

   // Vector retire, qualified here by the head flag
   input  wire                        i_vec_nonstore_commit,
   input  wire                        i_head_last,

   // Scalar write-backs
   input  vfp_pkg::scalar_wb_s        i_int_wb,
   input  vfp_pkg::scalar_wb_s        i_fp_wb,

   output vfp_pkg::commit_status_s    o_commit,
   output logic [VLEN*8-1:0]          o_commit_data
);

   localparam int CNT_W = $clog2(vfp_pkg::LMUL_MAX);
   localparam int XW    = vfp_pkg::XDATA_W;

   // Group registers written so far
   logic [VLEN*8-1:0]     wrdata_reg;
   vfp_pkg::lmul_mask_t   wrmask_reg;
   vfp_pkg::fflags_t      wrexc_reg;

   // Stored state plus this cycle's write
   logic [VLEN*8-1:0]     wrdata_nxt;
   vfp_pkg::lmul_mask_t   wrmask_nxt;
   vfp_pkg::fflags_t      wrexc_nxt;

   // Slot of the next write in the group
   logic [CNT_W-1:0]      lmul_cnt;

   logic                  commit_valid;

   always_comb begin
      wrdata_nxt = wrdata_reg;
      wrmask_nxt = wrmask_reg;
      wrexc_nxt  = wrexc_reg;
      if (i_vrf_wr) begin
         wrdata_nxt[VLEN*lmul_cnt +: VLEN] = i_vrf_wrdata;
         wrmask_nxt[lmul_cnt]              = |i_csr_vl;
         wrexc_nxt                         = wrexc_reg | i_vrf_wrexc;
      end
   end

   // Any commit retires the group, scalar or vector
   assign commit_valid = i_int_wb.valid || i_fp_wb.valid ||
                         (i_vec_nonstore_commit && i_head_last);

   always_ff @(posedge i_clk, posedge i_reset) begin
      if (i_reset) begin
         lmul_cnt   <= '0;
         wrdata_reg <= '0;
         wrmask_reg <= '0;
         wrexc_reg  <= '0;
      end else if (commit_valid) begin
         lmul_cnt   <= '0;
         wrdata_reg <= '0;
         wrmask_reg <= '0;
         wrexc_reg  <= '0;
      end else if (i_vrf_wr) begin
         lmul_cnt   <= lmul_cnt + 1'b1;
         wrdata_reg <= wrdata_nxt;
         wrmask_reg <= wrmask_nxt;
         wrexc_reg  <= wrexc_nxt;
      end
   end

   // Upper part only carries vector data
   assign o_commit_data[VLEN*8-1:XW] = {(VLEN*8-XW){i_vec_nonstore_commit}} &
                                       wrdata_nxt[VLEN*8-1:XW];

   // Low word is shared by all three sources
   assign o_commit_data[XW-1:0] = ({XW{i_vec_nonstore_commit}} & wrdata_nxt[XW-1:0]) |
                                  ({XW{i_int_wb.valid}}        & i_int_wb.data)      |
                                  ({XW{i_fp_wb.valid}}         & i_fp_wb.data);

   assign o_commit.valid  = commit_valid;
   assign o_commit.mask   = wrmask_nxt;
   assign o_commit.fflags = {$bits(vfp_pkg::fflags_t){i_vec_nonstore_commit}} & wrexc_nxt;

endmodule

`default_nettype wire

/* hw/vfp_commit_path.sv */
// Top of the vector/FP commit path; wires the last-flag tracker, commit accumulator and request filter
`timescale 1ns/1ps
`default_nettype none

module vfp_commit_path #(
   parameter int VLEN = 256
) (
   input  wire                        i_clk,
   input  wire                        i_reset,

   input  wire [$clog2(VLEN+1)-1:0]   i_csr_vl,

   // Load queue control
   input  vfp_pkg::lq_alloc_s         i_lq_alloc,
   input  wire                        i_lq_commit,

   // Vector register writes
   input  wire                        i_vrf_wr,
   input  wire [VLEN-1:0]             i_vrf_wrdata,
   input  vfp_pkg::fflags_t           i_vrf_wrexc,
   input  wire                        i_vec_nonstore_commit,

   // Scalar write-backs
   input  vfp_pkg::scalar_wb_s        i_int_wb,
   input  vfp_pkg::scalar_wb_s        i_fp_wb,

   // Memory request from the load queue
   input  wire                        i_data_req_prequal,
   input  wire                        i_mem_load,
   input  wire [VLEN/8-1:0]           i_data_byten,
   input  vfp_pkg::req_id_t           i_data_req_id,
   input  wire                        i_mem_last_raw,
   input  wire                        i_data_req_rtr,

   // Commit interface
   output vfp_pkg::commit_status_s    o_commit,
   output logic [VLEN*8-1:0]          o_commit_data,

   // Memory interface
   output logic                       o_data_req,
   output logic                       o_mem_last,
   output vfp_pkg::synth_resp_s       o_synth_resp
);

   // Flag of the entry at the retire pointer
   logic head_last;

   // Flag of the entry named by the request id
   logic req_last;

   vfp_lq_last_tracker u_lq_last_tracker (
      .i_clk       (i_clk),
      .i_reset     (i_reset),
      .i_lq_alloc  (i_lq_alloc),
      .i_lq_commit (i_lq_commit),
      .i_req_lqid  (i_data_req_id[vfp_pkg::LQ_ID_W-1:0]),
      .o_head_last (head_last),
      .o_req_last  (req_last)
   );

   vfp_commit_accumulator #(
      .VLEN (VLEN)
   ) u_commit_accumulator (
      .i_clk                 (i_clk),
      .i_reset               (i_reset),
      .i_csr_vl              (i_csr_vl),
      .i_vrf_wr              (i_vrf_wr),
      .i_vrf_wrdata          (i_vrf_wrdata),
      .i_vrf_wrexc           (i_vrf_wrexc),
      .i_vec_nonstore_commit (i_vec_nonstore_commit),
      .i_head_last           (head_last),
      .i_int_wb              (i_int_wb),
      .i_fp_wb               (i_fp_wb),
      .o_commit              (o_commit),
      .o_commit_data         (o_commit_data)
   );

   vfp_mem_req_filter #(
      .VLEN (VLEN)
   ) u_mem_req_filter (
      .i_clk              (i_clk),
      .i_reset            (i_reset),
      .i_data_req_prequal (i_data_req_prequal),
      .i_mem_load         (i_mem_load),
      .i_data_byten       (i_data_byten),
      .i_data_req_id      (i_data_req_id),
      .i_data_req_rtr     (i_data_req_rtr),
      .i_mem_last_raw     (i_mem_last_raw),
      .i_req_last         (req_last),
      .o_data_req         (o_data_req),
      .o_mem_last         (o_mem_last),
      .o_synth_resp       (o_synth_resp)
   );

endmodule

`default_nettype wire

/* hw/vfp_lq_last_tracker.sv */
// Load-queue "last micro-op" flag table with the retire read pointer, read at head and request
`timescale 1ns/1ps
`default_nettype none

module vfp_lq_last_tracker (
   input  wire                   i_clk,
   input  wire                   i_reset,

   // Allocation and done from the decoder
   input  vfp_pkg::lq_alloc_s    i_lq_alloc,

   // Retirement of the head entry
   input  wire                   i_lq_commit,

   // Queue index of the outgoing memory request
   input  vfp_pkg::lq_id_t       i_req_lqid,

   output logic                  o_head_last,
   output logic                  o_req_last
);

   // One flag per entry, set when the entry closes its instruction
   logic [vfp_pkg::LQ_DEPTH-1:0] lq_last;

   // Head of the queue as seen by retirement
   vfp_pkg::lq_id_t              lq_rd_ptr;

   // Entry taken by the most recent alloc
   vfp_pkg::lq_id_t              alloc_id_r;

   always_ff @(posedge i_clk, posedge i_reset) begin
      if (i_reset) begin
         lq_rd_ptr <= '0;
      end else if (i_lq_commit) begin
         // Wraps at the queue depth
         lq_rd_ptr <= vfp_pkg::lq_id_t'(lq_rd_ptr + 1'b1);
      end
   end

   always_ff @(posedge i_clk, posedge i_reset) begin
      if (i_reset) begin
         lq_last    <= '0;
         alloc_id_r <= '0;
      end else begin
         if (i_lq_alloc.alloc) begin
            lq_last[i_lq_alloc.nxt_id] <= i_lq_alloc.done;
            alloc_id_r                 <= i_lq_alloc.nxt_id;
         end else if (i_lq_alloc.done) begin
            // Late done marks the entry allocated earlier
            lq_last[alloc_id_r] <= 1'b1;
         end
      end
   end

   assign o_head_last = lq_last[lq_rd_ptr];
   assign o_req_last  = lq_last[i_req_lqid];

endmodule

`default_nettype wire

/* hw/vfp_mem_req_filter.sv */
// Drops zero-byte loads from the memory request, qualifies the last flag and answers them locally
`timescale 1ns/1ps
`default_nettype none

module vfp_mem_req_filter #(
   parameter int VLEN = 256
) (
   input  wire                    i_clk,
   input  wire                    i_reset,

   // Request as issued by the load queue
   input  wire                    i_data_req_prequal,
   input  wire                    i_mem_load,
   input  wire [VLEN/8-1:0]       i_data_byten,
   input  vfp_pkg::req_id_t       i_data_req_id,
   input  wire                    i_data_req_rtr,
   input  wire                    i_mem_last_raw,

   // Last flag of the request's queue entry
   input  wire                    i_req_last,

   output logic                   o_data_req,
   output logic                   o_mem_last,
   output vfp_pkg::synth_resp_s   o_synth_resp
);

   logic              zero_byte_load;
   logic              synth_fire;
   logic              synth_vld;
   vfp_pkg::req_id_t  synth_id;

   // A load with nothing enabled never goes to memory
   assign zero_byte_load = i_mem_load && ~|i_data_byten;
   assign synth_fire     = i_data_req_prequal && i_data_req_rtr && zero_byte_load;

   assign o_data_req = i_data_req_prequal && !zero_byte_load;
   assign o_mem_last = i_mem_last_raw && i_req_last;

   always_ff @(posedge i_clk, posedge i_reset) begin
      if (i_reset) begin
         synth_vld <= 1'b0;
      end else begin
         synth_vld <= synth_fire;
      end
   end

   always_ff @(posedge i_clk) begin
      if (synth_fire) begin
         synth_id <= i_data_req_id;
      end
   end

   // One cycle after acceptance
   assign o_synth_resp.valid = synth_vld;
   assign o_synth_resp.id    = synth_id;

endmodule

`default_nettype wire

/* hw/vfp_pkg.sv */
// Shared constants, widths and bundles for the vector/FP commit path; referenced by scoped name
`default_nettype none

package vfp_pkg;

   // Load queue geometry
   localparam int LQ_DEPTH = 8;
   localparam int LQ_ID_W  = 3;

   // Largest register group one instruction can write
   localparam int LMUL_MAX = 8;

   // Scalar write-back width
   localparam int XDATA_W  = 64;

   // Memory request id, low LQ_ID_W bits are the queue index
   localparam int REQ_ID_W = 12;

   typedef logic [LQ_ID_W-1:0]  lq_id_t;
   typedef logic [REQ_ID_W-1:0] req_id_t;
   typedef logic [4:0]          fflags_t;
   typedef logic [LMUL_MAX-1:0] lmul_mask_t;
   typedef logic [2:0]          mem_size_t;

   // Integer or FP register write-back
   typedef struct packed {
      logic               valid;
      logic [XDATA_W-1:0] data;
   } scalar_wb_s;

   // Decoder side of the load queue
   typedef struct packed {
      logic   alloc;
      logic   done;
      lq_id_t nxt_id;
   } lq_alloc_s;

   // Retire status that goes with the wide commit data
   typedef struct packed {
      logic       valid;
      lmul_mask_t mask;
      fflags_t    fflags;
   } commit_status_s;

   // Response returned locally for a load with no enabled bytes
   typedef struct packed {
      logic    valid;
      req_id_t id;
   } synth_resp_s;

endpackage

`default_nettype wire

/* sim.f */
+incdir+verification
hw/vfp_pkg.sv
hw/vfp_lq_last_tracker.sv
hw/vfp_commit_accumulator.sv
hw/vfp_mem_req_filter.sv
hw/vfp_commit_path.sv
verification/tb_vfp_commit_path.sv

/* verification/vfp_commit_path_tests.svh */
// Directed test tasks for the commit path, included inside the testbench module
`ifndef VFP_COMMIT_PATH_TESTS_SVH
`define VFP_COMMIT_PATH_TESTS_SVH

task automatic random_vreg(output logic [VLEN-1:0] vreg);
   for (int w = 0; w < VLEN/32; w++) begin
      vreg[w*32 +: 32] = $random(seed);
   end
endtask

// Clears the request each cycle until the synthetic response shows up
task automatic wait_synth_resp(output int cycles);
   cycles = 0;
   do begin
      @(negedge i_clk);
      clear_request();
      cycles++;
   end while (!o_synth_resp.valid && cycles < TIMEOUT_CYCLES);
   if (!o_synth_resp.valid) begin
      $display("Timeout: no synthetic response within %0d cycles", TIMEOUT_CYCLES);
      timeouts++;
   end
endtask

task automatic scalar_commit();
   logic [63:0]       data;
   logic [VLEN*8-1:0] expected;
   for (int src = 0; src < 2; src++) begin
      @(negedge i_clk);
      data = {$random(seed), $random(seed)};
      if (src == 0) begin
         i_int_wb = '{valid: 1'b1, data: data};
      end else begin
         i_fp_wb = '{valid: 1'b1, data: data};
      end
      #(CLK_PERIOD/4);
      expected       = '0;
      expected[63:0] = data;
      check_value("scalar_commit valid", 1, o_commit.valid);
      check_value("scalar_commit data", expected, o_commit_data);
      check_value("scalar_commit mask", 0, o_commit.mask);
      check_value("scalar_commit fflags", 0, o_commit.fflags);
      @(negedge i_clk);
      i_int_wb = '0;
      i_fp_wb  = '0;
   end
endtask

task automatic last_flag_tracking();
   @(negedge i_clk);
   i_mem_last_raw = 1'b1;
   i_data_req_id  = 12'h3a2;
   #(CLK_PERIOD/4);
   check_value("last_flag before alloc", 0, o_mem_last);
   @(negedge i_clk);
   i_lq_alloc = '{alloc: 1'b1, done: 1'b1, nxt_id: 3'd2};
   #(CLK_PERIOD/4);
   check_value("last_flag same cycle as alloc", 0, o_mem_last);
   @(negedge i_clk);
   i_lq_alloc = '0;
   #(CLK_PERIOD/4);
   check_value("last_flag after alloc with done", 1, o_mem_last);
   @(negedge i_clk);
   i_mem_last_raw = 1'b0;
   #(CLK_PERIOD/4);
   check_value("last_flag raw low", 0, o_mem_last);
   // Entry 5 gets its done late
   @(negedge i_clk);
   i_mem_last_raw = 1'b1;
   i_data_req_id  = 12'h7c5;
   i_lq_alloc     = '{alloc: 1'b1, done: 1'b0, nxt_id: 3'd5};
   @(negedge i_clk);
   i_lq_alloc = '0;
   #(CLK_PERIOD/4);
   check_value("last_flag before late done", 0, o_mem_last);
   @(negedge i_clk);
   i_lq_alloc.done = 1'b1;
   #(CLK_PERIOD/4);
   check_value("last_flag same cycle as done", 0, o_mem_last);
   @(negedge i_clk);
   i_lq_alloc = '0;
   #(CLK_PERIOD/4);
   check_value("last_flag after late done", 1, o_mem_last);
   @(negedge i_clk);
   i_mem_last_raw = 1'b0;
   i_data_req_id  = '0;
endtask

task automatic head_pointer_gating();
   @(negedge i_clk);
   i_vec_nonstore_commit = 1'b1;
   #(CLK_PERIOD/4);
   check_value("head_gating entry 0", 0, o_commit.valid);
   // Flagged entries are 2 and 5, so the second advance reaches one
   for (int p = 1; p <= 2; p++) begin
      @(negedge i_clk);
      i_vec_nonstore_commit = 1'b0;
      i_lq_commit           = 1'b1;
      @(negedge i_clk);
      i_lq_commit           = 1'b0;
      i_vec_nonstore_commit = 1'b1;
      #(CLK_PERIOD/4);
      check_value($sformatf("head_gating entry %0d", p), (p == 2), o_commit.valid);
   end
   @(negedge i_clk);
   i_vec_nonstore_commit = 1'b0;
endtask

task automatic vector_group_assembly();
   logic [VLEN*8-1:0]   expected;
   logic [VLEN-1:0]     vreg;
   logic [63:0]         data;
   vfp_pkg::fflags_t    exc;
   vfp_pkg::fflags_t    exc_or;
   vfp_pkg::lmul_mask_t mask_exp;
   i_csr_vl = 40;
   for (int n = 1; n <= vfp_pkg::LMUL_MAX; n++) begin
      expected = '0;
      exc_or   = '0;
      mask_exp = '0;
      for (int k = 0; k < n; k++) begin
         @(negedge i_clk);
         random_vreg(vreg);
         exc          = vfp_pkg::fflags_t'($random(seed));
         i_vrf_wr     = 1'b1;
         i_vrf_wrdata = vreg;
         i_vrf_wrexc  = exc;
         expected[k*VLEN +: VLEN] = vreg;
         mask_exp[k]  = 1'b1;
         exc_or       = exc_or | exc;
      end
      @(negedge i_clk);
      i_vrf_wr              = 1'b0;
      i_vrf_wrdata          = '0;
      i_vrf_wrexc           = '0;
      i_vec_nonstore_commit = 1'b1;
      #(CLK_PERIOD/4);
      check_value($sformatf("vector_group n=%0d valid", n), 1, o_commit.valid);
      check_value($sformatf("vector_group n=%0d data", n), expected, o_commit_data);
      check_value($sformatf("vector_group n=%0d mask", n), mask_exp, o_commit.mask);
      check_value($sformatf("vector_group n=%0d fflags", n), exc_or, o_commit.fflags);
      // Next scalar commit must see an empty buffer
      @(negedge i_clk);
      i_vec_nonstore_commit = 1'b0;
      data     = {$random(seed), $random(seed)};
      i_int_wb = '{valid: 1'b1, data: data};
      #(CLK_PERIOD/4);
      expected       = '0;
      expected[63:0] = data;
      check_value($sformatf("vector_group n=%0d cleared data", n), expected, o_commit_data);
      check_value($sformatf("vector_group n=%0d cleared mask", n), 0, o_commit.mask);
      @(negedge i_clk);
      i_int_wb = '0;
   end
   i_csr_vl = '0;
endtask

task automatic zero_byte_filter();
   vfp_pkg::req_id_t id;
   int               cycles;
   @(negedge i_clk);
   id                 = vfp_pkg::req_id_t'($random(seed));
   i_data_req_prequal = 1'b1;
   i_mem_load         = 1'b1;
   i_data_req_id      = id;
   i_data_req_rtr     = 1'b1;
   #(CLK_PERIOD/4);
   check_value("zero_byte load request", 0, o_data_req);
   wait_synth_resp(cycles);
   if (o_synth_resp.valid) begin
      check_value("zero_byte response latency", 1, cycles);
      check_value("zero_byte response id", id, o_synth_resp.id);
   end
   // Not accepted while rtr is low
   @(negedge i_clk);
   i_data_req_prequal = 1'b1;
   i_mem_load         = 1'b1;
   i_data_req_id      = vfp_pkg::req_id_t'($random(seed));
   #(CLK_PERIOD/4);
   check_value("zero_byte rtr low request", 0, o_data_req);
   @(negedge i_clk);
   clear_request();
   #(CLK_PERIOD/4);
   check_value("zero_byte rtr low response", 0, o_synth_resp.valid);
   @(negedge i_clk);
   i_data_req_prequal = 1'b1;
   i_data_req_rtr     = 1'b1;
   #(CLK_PERIOD/4);
   check_value("zero_byte store request", 1, o_data_req);
   @(negedge i_clk);
   i_mem_load   = 1'b1;
   i_data_byten = {$random(seed)} | 32'h1;
   #(CLK_PERIOD/4);
   check_value("zero_byte store response", 0, o_synth_resp.valid);
   check_value("zero_byte enabled load request", 1, o_data_req);
   @(negedge i_clk);
   clear_request();
   #(CLK_PERIOD/4);
   check_value("zero_byte enabled load response", 0, o_synth_resp.valid);
endtask

`endif

/* verification/tb_vfp_commit_path.sv */
// Testbench top for the vector/FP commit path; runs the directed tests and reports the result
`timescale 1ns/1ps
`default_nettype none

module tb_vfp_commit_path;

   localparam int VLEN           = 256;
   localparam int CLK_PERIOD     = 40;
   localparam int TIMEOUT_CYCLES = 20;

   integer seed = 32'h2a4c;
   int     checks;
   int     value_errors;
   int     timeouts;

   logic                             i_clk;
   logic                             i_reset;
   logic [$clog2(VLEN+1)-1:0]        i_csr_vl;
   vfp_pkg::lq_alloc_s               i_lq_alloc;
   logic                             i_lq_commit;
   logic                             i_vrf_wr;
   logic [VLEN-1:0]                  i_vrf_wrdata;
   vfp_pkg::fflags_t                 i_vrf_wrexc;
   logic                             i_vec_nonstore_commit;
   vfp_pkg::scalar_wb_s              i_int_wb;
   vfp_pkg::scalar_wb_s              i_fp_wb;
   logic                             i_data_req_prequal;
   logic                             i_mem_load;
   logic [VLEN/8-1:0]                i_data_byten;
   vfp_pkg::req_id_t                 i_data_req_id;
   logic                             i_mem_last_raw;
   logic                             i_data_req_rtr;
   vfp_pkg::commit_status_s          o_commit;
   logic [VLEN*8-1:0]                o_commit_data;
   logic                             o_data_req;
   logic                             o_mem_last;
   vfp_pkg::synth_resp_s             o_synth_resp;

   vfp_commit_path #(
      .VLEN (VLEN)
   ) dut (
      .i_clk                 (i_clk),
      .i_reset               (i_reset),
      .i_csr_vl              (i_csr_vl),
      .i_lq_alloc            (i_lq_alloc),
      .i_lq_commit           (i_lq_commit),
      .i_vrf_wr              (i_vrf_wr),
      .i_vrf_wrdata          (i_vrf_wrdata),
      .i_vrf_wrexc           (i_vrf_wrexc),
      .i_vec_nonstore_commit (i_vec_nonstore_commit),
      .i_int_wb              (i_int_wb),
      .i_fp_wb               (i_fp_wb),
      .i_data_req_prequal    (i_data_req_prequal),
      .i_mem_load            (i_mem_load),
      .i_data_byten          (i_data_byten),
      .i_data_req_id         (i_data_req_id),
      .i_mem_last_raw        (i_mem_last_raw),
      .i_data_req_rtr        (i_data_req_rtr),
      .o_commit              (o_commit),
      .o_commit_data         (o_commit_data),
      .o_data_req            (o_data_req),
      .o_mem_last            (o_mem_last),
      .o_synth_resp          (o_synth_resp)
   );

   initial begin
      i_clk = 1'b0;
      forever #(CLK_PERIOD/2) i_clk = ~i_clk;
   end

   initial begin
      checks                = 0;
      value_errors          = 0;
      timeouts              = 0;
      i_reset               = 1'b1;
      i_csr_vl              = '0;
      i_lq_alloc            = '0;
      i_lq_commit           = 1'b0;
      i_vrf_wr              = 1'b0;
      i_vrf_wrdata          = '0;
      i_vrf_wrexc           = '0;
      i_vec_nonstore_commit = 1'b0;
      i_int_wb              = '0;
      i_fp_wb               = '0;
      i_mem_last_raw        = 1'b0;
      clear_request();
      repeat (3) @(posedge i_clk);
      @(negedge i_clk);
      i_reset = 1'b0;

      // Head pointer test relies on the flags set by the tracking test
      scalar_commit();
      last_flag_tracking();
      head_pointer_gating();
      vector_group_assembly();
      zero_byte_filter();

      @(negedge i_clk);
      $display("Checks: %0d, value errors: %0d, timeouts: %0d", checks, value_errors, timeouts);
      if (value_errors == 0 && timeouts == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

   task automatic check_value(input string name, input logic [VLEN*8-1:0] expected,
                              input logic [VLEN*8-1:0] actual);
      checks++;
      assert (actual === expected) else begin
         $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
         value_errors++;
      end
   endtask

   task automatic clear_request();
      i_data_req_prequal = 1'b0;
      i_mem_load         = 1'b0;
      i_data_byten       = '0;
      i_data_req_id      = '0;
      i_data_req_rtr     = 1'b0;
   endtask

   `include "vfp_commit_path_tests.svh"

endmodule

`default_nettype wire
